// ==== dcache_top.f ====
verilog/dcache_pkg.sv
verilog/cache_array.sv
verilog/tree_plru.sv
verilog/miss_handler.sv
verilog/load_result.sv
verilog/dcache_top.sv
tests/dcache_top_tb.sv

// ==== tests/dcache_top_tb.sv ====
`timescale 1ns/10ps

module dcache_top_tb;
    import dcache_pkg::*;

    // several times the length of all tests together
    localparam int max_cycles = 2000;

    logic           clock;
    logic           reset;
    logic           flush;
    logic           load_valid;
    load_request_t  load_request;
    logic           store_valid;
    store_request_t store_request;
    mem_response_t  mem_response;
    logic           load_ready;
    load_result_t   result;
    mem_request_t   mem_request;

    // memory model
    logic [7:0]             ref_mem [1 << addr_len];
    logic                   pend_valid [16];
    logic [block_bits-1:0]  pend_data [16];
    int                     pend_due [16];
    logic [mem_tag_len-1:0] next_tag;
    logic                   tag_used;
    logic [mem_tag_len-1:0] return_tag;
    logic [block_bits-1:0]  return_data;
    logic [31:0]            lcg_state;
    int                     forced_delays [$];

    load_result_t observed_results [$];
    load_result_t expected_results [$];
    logic         last_hit;
    int           cycles;
    int           errors;
    int           checks;
    int           tests;

    // every load command is granted in the cycle it is shown
    assign mem_response = {mem_request.command == bus_load, next_tag, return_tag, return_data};

    dcache_top dcache_top_inst (
        .clock(clock), .reset(reset), .flush(flush),
        .load_valid(load_valid), .load_request(load_request),
        .store_valid(store_valid), .store_request(store_request),
        .mem_response(mem_response),
        .load_ready(load_ready), .result(result), .mem_request(mem_request)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [7:0] initial_byte(input logic [addr_len-1:0] addr);
        return 8'((addr[7:0] + addr[15:8]) * 3);
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [block_bits-1:0] read_block(input logic [addr_len-1:0] addr);
        logic [block_bits-1:0] block;
        for (int i = 0; i < 8; i++) begin
            block[8*i +: 8] = ref_mem[{addr[15:3], 3'(i)}];
        end
        return block;
    endfunction

    // little endian and aligned down to the access size
    function automatic logic [word_len-1:0] load_value(input logic [addr_len-1:0] addr,
                                                      input mem_size_t size,
                                                      input logic is_signed);
        logic [addr_len-1:0] base;
        logic [word_len-1:0] value;
        case (size)
            mem_byte: value = {{24{is_signed & ref_mem[addr][7]}}, ref_mem[addr]};
            mem_half: begin
                base  = {addr[15:1], 1'b0};
                value = {{16{is_signed & ref_mem[base+1][7]}}, ref_mem[base+1], ref_mem[base]};
            end
            default: begin
                base  = {addr[15:2], 2'b00};
                value = {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
            end
        endcase
        return value;
    endfunction

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: no end of run after %0d cycles", max_cycles);
            $display("sim failed");
            $finish;
        end
    end

    always @(negedge clock) begin
        if (result.valid === 1'b1) begin
            observed_results.push_back(result);
        end
    end

    // block data is read out of the reference memory at grant time
    always @(negedge clock) begin
        if (mem_request.command === bus_load) begin
            pend_valid[next_tag] = 1'b1;
            pend_data[next_tag]  = read_block(mem_request.addr);
            if (forced_delays.size() > 0) begin
                pend_due[next_tag] = cycles + forced_delays.pop_front();
            end else begin
                lcg_state          = lcg_next(lcg_state);
                pend_due[next_tag] = cycles + 3 + lcg_state[17:16];
            end
            tag_used = 1'b1;
        end
    end

    // at most one return per cycle and the lowest due tag goes first
    always @(posedge clock) begin : return_select
        logic found;
        #2;
        if (tag_used) begin
            next_tag = next_tag == 4'd15 ? 4'd1 : next_tag + 4'd1;
        end
        tag_used    = 1'b0;
        return_tag  = '0;
        return_data = '0;
        found       = 1'b0;
        for (int t = 1; t < 16; t++) begin
            if (!found && pend_valid[t] && pend_due[t] <= cycles) begin
                found         = 1'b1;
                pend_valid[t] = 1'b0;
                return_tag    = mem_tag_len'(t);
                return_data   = pend_data[t];
            end
        end
    end

    task automatic step();
        @(posedge clock);
        #2;
    endtask

    task automatic check_result(input load_result_t expected, input load_result_t actual,
                                input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic check_mem_request(input mem_request_t expected, input mem_request_t actual,
                                     input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic send_load(input logic [addr_len-1:0] addr, input mem_size_t size,
                             input logic is_signed, input logic [rob_len-1:0] rob,
                             input logic track);
        load_result_t expect_result;
        while (!load_ready) begin
            step();
        end
        load_valid    = 1'b1;
        load_request  = {addr, size, is_signed, preg_len'(rob + 7), rob};
        expect_result = {1'b1, load_value(addr, size, is_signed), preg_len'(rob + 7), rob};
        #1;
        // a hit answers in this very cycle
        last_hit = result.valid && result.rob == rob;
        if (track) begin
            expected_results.push_back(expect_result);
        end
        step();
        load_valid = 1'b0;
    endtask

    task automatic send_store(input logic [addr_len-1:0] addr, input mem_size_t size,
                              input logic [word_len-1:0] data);
        logic [addr_len-1:0] base;
        int                  bytes;
        store_valid   = 1'b1;
        store_request = {addr, size, data};
        #1;
        check_mem_request({bus_store, addr, size, 64'(data)}, mem_request, "mem_request");
        bytes = size == mem_byte ? 1 : size == mem_half ? 2 : 4;
        base  = addr & ~16'(bytes - 1);
        for (int i = 0; i < bytes; i++) begin
            ref_mem[base + i] = data[8*i +: 8];
        end
        step();
        store_valid = 1'b0;
    endtask

    task automatic drain_results();
        while (observed_results.size() < expected_results.size()) begin
            step();
        end
        while (expected_results.size() > 0) begin
            check_result(expected_results.pop_front(), observed_results.pop_front(), "result");
        end
        if (observed_results.size() != 0) begin
            errors++;
            $display("a load result came back that no load asked for");
            observed_results.delete();
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic reset_test();
        int start;
        start = errors;
        check_flag("load_ready", 1'b1, load_ready);
        check_result('0, result, "result");
        check_mem_request('0, mem_request, "mem_request");
        report_test("reset state", start);
    endtask

    task automatic cold_miss_test();
        int start;
        start = errors;
        send_load(16'h0044, mem_word, 1'b0, 5'd1, 1'b1);
        check_flag("load hit", 1'b0, last_hit);
        #1;
        check_mem_request({bus_load, 16'h0040, mem_double, 64'h0}, mem_request, "mem_request");
        drain_results();
        send_load(16'h0040, mem_word, 1'b0, 5'd2, 1'b1);
        check_flag("load hit", 1'b1, last_hit);
        #1;
        check_mem_request('0, mem_request, "mem_request");
        drain_results();
        report_test("cold miss then hit", start);
    endtask

    // block 0x0050 holds bytes of both signs
    task automatic size_test();
        int start;
        start = errors;
        send_load(16'h0050, mem_byte, 1'b1, 5'd3, 1'b1);
        drain_results();
        send_load(16'h0051, mem_byte, 1'b1, 5'd4, 1'b1);
        send_load(16'h0055, mem_byte, 1'b0, 5'd5, 1'b1);
        send_load(16'h0056, mem_byte, 1'b1, 5'd6, 1'b1);
        send_load(16'h0054, mem_half, 1'b1, 5'd7, 1'b1);
        send_load(16'h0052, mem_half, 1'b0, 5'd8, 1'b1);
        send_load(16'h0056, mem_half, 1'b1, 5'd9, 1'b1);
        send_load(16'h0054, mem_word, 1'b0, 5'd10, 1'b1);
        send_load(16'h0050, mem_word, 1'b1, 5'd11, 1'b1);
        drain_results();
        report_test("sizes and extension", start);
    endtask

    task automatic store_test();
        int start;
        start = errors;
        send_load(16'h0098, mem_word, 1'b0, 5'd12, 1'b1);
        send_store(16'h0200, mem_word, 32'h1234_5678);
        drain_results();
        send_store(16'h0051, mem_byte, 32'h0000_00a5);
        send_store(16'h0054, mem_half, 32'h0000_beef);
        send_load(16'h0050, mem_word, 1'b0, 5'd13, 1'b1);
        send_load(16'h0054, mem_word, 1'b0, 5'd14, 1'b1);
        send_load(16'h0051, mem_byte, 1'b1, 5'd15, 1'b1);
        drain_results();
        send_load(16'h0200, mem_word, 1'b0, 5'd16, 1'b1);
        check_flag("load hit", 1'b0, last_hit);
        drain_results();
        report_test("store write-through and merge", start);
    endtask

    task automatic reorder_test();
        int start;
        start = errors;
        forced_delays = '{12, 9, 6};
        send_load(16'h0100, mem_word, 1'b0, 5'd17, 1'b1);
        send_load(16'h0108, mem_half, 1'b1, 5'd18, 1'b1);
        send_load(16'h0110, mem_byte, 1'b0, 5'd19, 1'b1);
        drain_results();
        report_test("reverse return, in-order retire", start);
    endtask

    task automatic replacement_test();
        int start;
        start = errors;
        // tags 1 to 5 all map to set 5
        for (int t = 1; t <= 5; t++) begin
            send_load(16'((t << 6) | 16'h0028), mem_word, 1'b0, 5'(t), 1'b1);
        end
        drain_results();
        send_load(16'h0068, mem_word, 1'b0, 5'd6, 1'b1);
        check_flag("load hit", 1'b0, last_hit);
        drain_results();
        // in set 6 way 0 is hit before the fifth fill
        for (int t = 1; t <= 4; t++) begin
            send_load(16'((t << 6) | 16'h0030), mem_word, 1'b0, 5'(t + 6), 1'b1);
        end
        drain_results();
        send_load(16'h0070, mem_word, 1'b0, 5'd11, 1'b1);
        send_load(16'h0170, mem_word, 1'b0, 5'd12, 1'b1);
        drain_results();
        send_load(16'h00b0, mem_word, 1'b0, 5'd13, 1'b1);
        check_flag("load hit", 1'b1, last_hit);
        send_load(16'h0130, mem_word, 1'b0, 5'd14, 1'b1);
        check_flag("load hit", 1'b1, last_hit);
        send_load(16'h0070, mem_word, 1'b0, 5'd15, 1'b1);
        check_flag("load hit", 1'b1, last_hit);
        send_load(16'h00f0, mem_word, 1'b0, 5'd16, 1'b1);
        check_flag("load hit", 1'b0, last_hit);
        drain_results();
        report_test("replacement", start);
    endtask

    task automatic flush_test();
        int start;
        start = errors;
        // returns held back until after the flush
        forced_delays = '{20, 20, 20, 20};
        send_load(16'h0078, mem_word, 1'b0, 5'd20, 1'b0);
        send_load(16'h00b8, mem_word, 1'b0, 5'd21, 1'b0);
        send_load(16'h00f8, mem_word, 1'b0, 5'd22, 1'b0);
        send_load(16'h0138, mem_word, 1'b0, 5'd23, 1'b0);
        flush = 1'b1;
        #1;
        check_flag("load_ready", 1'b0, load_ready);
        step();
        flush = 1'b0;
        #1;
        check_flag("load_ready", 1'b1, load_ready);
        repeat (30) begin
            step();
        end
        drain_results();
        send_load(16'h0178, mem_word, 1'b0, 5'd24, 1'b1);
        drain_results();
        report_test("flush and full", start);
    endtask

    initial begin
        reset         = 1'b1;
        flush         = 1'b0;
        load_valid    = 1'b0;
        load_request  = '0;
        store_valid   = 1'b0;
        store_request = '0;
        next_tag      = 4'd1;
        tag_used      = 1'b0;
        return_tag    = '0;
        return_data   = '0;
        lcg_state     = 32'hc69d7dfe;
        cycles        = 0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        for (int i = 0; i < 16; i++) begin
            pend_valid[i] = 1'b0;
        end
        for (int a = 0; a < (1 << addr_len); a++) begin
            ref_mem[a] = initial_byte(16'(a));
        end
        repeat (4) begin
            @(posedge clock);
        end
        #2;
        reset = 1'b0;
        #1;
        reset_test();
        cold_miss_test();
        size_test();
        store_test();
        reorder_test();
        replacement_test();
        flush_test();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       load_valid,
    input  dcache_pkg::load_request_t  load_request,
    input  logic                       store_valid,
    input  dcache_pkg::store_request_t store_request,
    input  dcache_pkg::mem_response_t  mem_response,
    output logic                       load_ready,
    output dcache_pkg::load_result_t   result,
    output dcache_pkg::mem_request_t   mem_request
);
    import dcache_pkg::*;

    logic                  load_hit;
    logic [way_len-1:0]    load_way;
    logic [block_bits-1:0] load_block;
    logic                  store_hit;
    logic [way_len-1:0]    store_way;
    logic [way_count-1:0]  set_valid;
    logic [way_len-1:0]    fill_way;
    miss_entry_t           head_entry;
    logic                  head_retire;

    // plru target is the hit way, else the block being filled
    logic                  take_hit;
    logic [set_len-1:0]    plru_set;
    logic [way_len-1:0]    plru_way;

    assign take_hit = load_valid && load_hit;
    assign plru_set = take_hit ? load_request.addr.set : head_entry.request.addr.set;
    assign plru_way = take_hit ? load_way : fill_way;

    cache_array cache_array_inst (
        .clock(clock), .reset(reset),
        .load_addr(load_request.addr),
        .store_valid(store_valid), .store_request(store_request),
        .fill_enable(head_retire), .fill_set(head_entry.request.addr.set),
        .fill_way(fill_way), .fill_tag(head_entry.request.addr.tag),
        .fill_data(head_entry.block),
        .load_hit(load_hit), .load_way(load_way), .load_block(load_block),
        .store_hit(store_hit), .store_way(store_way), .set_valid(set_valid)
    );

    tree_plru tree_plru_inst (
        .clock(clock), .reset(reset),
        .lookup_set(head_entry.request.addr.set), .set_valid(set_valid),
        .load_update(result.valid), .load_set(plru_set), .load_way(plru_way),
        .store_update(store_hit), .store_set(store_request.addr.set),
        .store_way(store_way),
        .fill_way(fill_way)
    );

    miss_handler miss_handler_inst (
        .clock(clock), .reset(reset), .flush(flush),
        .load_valid(load_valid), .load_request(load_request), .load_hit(load_hit),
        .store_valid(store_valid), .store_request(store_request),
        .mem_response(mem_response),
        .load_ready(load_ready), .mem_request(mem_request),
        .head_entry(head_entry), .head_retire(head_retire)
    );

    load_result load_result_inst (
        .load_valid(load_valid), .load_hit(load_hit),
        .load_request(load_request), .load_block(load_block),
        .head_retire(head_retire), .head_entry(head_entry),
        .result(result)
    );

endmodule

// ==== verilog/load_result.sv ====
`timescale 1ns/10ps

module load_result (
    input  logic                              load_valid,
    input  logic                              load_hit,
    input  dcache_pkg::load_request_t         load_request,
    input  logic [dcache_pkg::block_bits-1:0] load_block,
    input  logic                              head_retire,
    input  dcache_pkg::miss_entry_t           head_entry,
    output dcache_pkg::load_result_t          result
);
    import dcache_pkg::*;

    logic                  take_hit;
    load_request_t         source;
    logic [block_bits-1:0] source_block;
    logic [7:0]            sel_byte;
    logic [15:0]           sel_half;
    logic [word_len-1:0]   sel_word;

    assign take_hit     = load_valid && load_hit;
    assign source       = take_hit ? load_request : head_entry.request;
    assign source_block = take_hit ? load_block : head_entry.block;

    assign sel_byte = source_block[{source.addr.offset, 3'b000} +: 8];
    assign sel_half = source_block[{source.addr.offset[2:1], 4'b0000} +: 16];
    assign sel_word = source_block[{source.addr.offset[2], 5'b00000} +: 32];

    always_comb begin
        result = '0;
        if (take_hit || head_retire) begin
            result.valid = 1'b1;
            result.preg  = source.preg;
            result.rob   = source.rob;
            case (source.size)
                mem_byte: result.value = {{24{source.is_signed & sel_byte[7]}}, sel_byte};
                mem_half: result.value = {{16{source.is_signed & sel_half[15]}}, sel_half};
                default:  result.value = sel_word;
            endcase
        end
    end

endmodule

// ==== verilog/miss_handler.sv ====
`timescale 1ns/10ps

module miss_handler (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       load_valid,
    input  dcache_pkg::load_request_t  load_request,
    input  logic                       load_hit,
    input  logic                       store_valid,
    input  dcache_pkg::store_request_t store_request,
    input  dcache_pkg::mem_response_t  mem_response,
    output logic                       load_ready,
    output dcache_pkg::mem_request_t   mem_request,
    output dcache_pkg::miss_entry_t    head_entry,
    output logic                       head_retire
);
    import dcache_pkg::*;

    miss_entry_t [buffer_size-1:0] buffer;
    logic [buffer_len-1:0]         head_ptr;
    logic [buffer_len-1:0]         send_ptr;
    logic [buffer_len-1:0]         tail_ptr;
    logic                          full;

    miss_entry_t send_entry;
    logic        allocate;
    logic        granted;

    assign head_entry  = buffer[head_ptr];
    assign send_entry  = buffer[send_ptr];
    assign load_ready  = !full;
    assign allocate    = load_valid && !load_hit && !full;
    // a hit owns the result port this cycle
    assign head_retire = head_entry.valid && head_entry.done && !(load_valid && load_hit);
    assign granted     = mem_request.command == bus_load && mem_response.grant_valid &&
                         mem_response.grant_tag != '0;

    // stores go first, then the oldest unsent miss
    always_comb begin
        mem_request = '0;
        if (store_valid) begin
            mem_request.command = bus_store;
            mem_request.addr    = store_request.addr;
            mem_request.size    = store_request.size;
            mem_request.data    = {{(block_bits - word_len){1'b0}}, store_request.data};
        end else if (send_entry.valid && !send_entry.done && send_entry.mem_tag == '0) begin
            mem_request.command = bus_load;
            mem_request.addr    = {send_entry.request.addr.tag, send_entry.request.addr.set,
                                   {offset_len{1'b0}}};
            mem_request.size    = mem_double;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head_ptr <= '0;
            send_ptr <= '0;
            tail_ptr <= '0;
            full     <= 1'b0;
        end else begin
            if (allocate) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (head_retire) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (granted) begin
                send_ptr <= send_ptr + 1'b1;
            end
            if (allocate && !head_retire && tail_ptr + 1'b1 == head_ptr) begin
                full <= 1'b1;
            end else if (head_retire && !allocate) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            for (int i = 0; i < buffer_size; i++) begin
                buffer[i].valid <= 1'b0;
            end
        end else begin
            if (allocate) begin
                buffer[tail_ptr].valid   <= 1'b1;
                buffer[tail_ptr].done    <= 1'b0;
                buffer[tail_ptr].mem_tag <= '0;
                buffer[tail_ptr].request <= load_request;
            end
            if (head_retire) begin
                buffer[head_ptr].valid <= 1'b0;
            end
            if (granted) begin
                buffer[send_ptr].mem_tag <= mem_response.grant_tag;
            end
            // returns may come back in any order
            for (int i = 0; i < buffer_size; i++) begin
                if (buffer[i].valid && !buffer[i].done && mem_response.return_tag != '0 &&
                    buffer[i].mem_tag == mem_response.return_tag) begin
                    buffer[i].done  <= 1'b1;
                    buffer[i].block <= mem_response.return_data;
                end
            end
        end
    end

endmodule

// ==== verilog/tree_plru.sv ====
`timescale 1ns/10ps

module tree_plru (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [dcache_pkg::set_len-1:0]   lookup_set,
    input  logic [dcache_pkg::way_count-1:0] set_valid,
    input  logic                             load_update,
    input  logic [dcache_pkg::set_len-1:0]   load_set,
    input  logic [dcache_pkg::way_len-1:0]   load_way,
    input  logic                             store_update,
    input  logic [dcache_pkg::set_len-1:0]   store_set,
    input  logic [dcache_pkg::way_len-1:0]   store_way,
    output logic [dcache_pkg::way_len-1:0]   fill_way
);
    import dcache_pkg::*;

    // bit 0 picks the half, bit 1 the left pair, bit 2 the right pair
    logic [set_count-1:0][2:0] plru_bits;
    logic [2:0]                lookup_bits;
    logic [way_len-1:0]        victim_way;

    function automatic logic [2:0] touch(input logic [2:0] bits, input logic [way_len-1:0] way);
        logic [2:0] next;
        next = bits;
        case (way)
            2'd0:    next = {bits[2], 2'b11};
            2'd1:    next = {bits[2], 2'b01};
            2'd2:    next = {1'b1, bits[1], 1'b0};
            default: next = {1'b0, bits[1], 1'b0};
        endcase
        return next;
    endfunction

    assign lookup_bits = plru_bits[lookup_set];
    assign victim_way  = lookup_bits[0] ? {1'b1, lookup_bits[2]} : {1'b0, lookup_bits[1]};

    // lowest invalid way first
    always_comb begin
        fill_way = victim_way;
        for (int w = way_count - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                fill_way = way_len'(w);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            plru_bits <= '0;
        end else if (load_update) begin
            plru_bits[load_set] <= touch(plru_bits[load_set], load_way);
        end else if (store_update) begin
            plru_bits[store_set] <= touch(plru_bits[store_set], store_way);
        end
    end

endmodule

// ==== verilog/cache_array.sv ====
`timescale 1ns/10ps

module cache_array (
    input  logic                              clock,
    input  logic                              reset,
    input  dcache_pkg::cache_addr_t           load_addr,
    input  logic                              store_valid,
    input  dcache_pkg::store_request_t        store_request,
    input  logic                              fill_enable,
    input  logic [dcache_pkg::set_len-1:0]    fill_set,
    input  logic [dcache_pkg::way_len-1:0]    fill_way,
    input  logic [dcache_pkg::tag_len-1:0]    fill_tag,
    input  logic [dcache_pkg::block_bits-1:0] fill_data,
    output logic                              load_hit,
    output logic [dcache_pkg::way_len-1:0]    load_way,
    output logic [dcache_pkg::block_bits-1:0] load_block,
    output logic                              store_hit,
    output logic [dcache_pkg::way_len-1:0]    store_way,
    output logic [dcache_pkg::way_count-1:0]  set_valid
);
    import dcache_pkg::*;

    logic [set_count-1:0][way_count-1:0]              valid_array;
    logic [set_count-1:0][way_count-1:0][tag_len-1:0] tag_array;
    logic [block_bits-1:0] data_array [set_count][way_count];

    logic [way_len:0]      load_match;
    logic [way_len:0]      store_match;
    logic [block_bits-1:0] merged_block;

    // returns {hit, way} for one set
    function automatic logic [way_len:0] find_way(
        input logic [tag_len-1:0]                  tag,
        input logic [way_count-1:0]                valids,
        input logic [way_count-1:0][tag_len-1:0]   tags
    );
        logic [way_len:0] found;
        found = '0;
        for (int w = 0; w < way_count; w++) begin
            if (valids[w] && tags[w] == tag) begin
                found = {1'b1, way_len'(w)};
            end
        end
        return found;
    endfunction

    assign load_match  = find_way(load_addr.tag, valid_array[load_addr.set],
                                  tag_array[load_addr.set]);
    assign store_match = find_way(store_request.addr.tag, valid_array[store_request.addr.set],
                                  tag_array[store_request.addr.set]);

    assign load_hit   = load_match[way_len];
    assign load_way   = load_match[way_len-1:0];
    assign load_block = data_array[load_addr.set][load_way];
    assign store_hit  = store_valid && store_match[way_len];
    assign store_way  = store_match[way_len-1:0];
    assign set_valid  = valid_array[fill_set];

    // store bytes laid over the hit block
    always_comb begin
        merged_block = data_array[store_request.addr.set][store_way];
        case (store_request.size)
            mem_byte: merged_block[{store_request.addr.offset, 3'b000} +: 8] =
                store_request.data[7:0];
            mem_half: merged_block[{store_request.addr.offset[2:1], 4'b0000} +: 16] =
                store_request.data[15:0];
            default:  merged_block[{store_request.addr.offset[2], 5'b00000} +: 32] =
                store_request.data;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_array <= '0;
        end else if (fill_enable) begin
            valid_array[fill_set][fill_way] <= 1'b1;
        end
    end

    // fill comes last so an evicted block never keeps a late store
    always_ff @(posedge clock) begin
        if (store_hit) begin
            data_array[store_request.addr.set][store_way] <= merged_block;
        end
        if (fill_enable) begin
            tag_array[fill_set][fill_way]  <= fill_tag;
            data_array[fill_set][fill_way] <= fill_data;
        end
    end

endmodule

// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

    // address geometry
    localparam int addr_len    = 16;
    localparam int offset_len  = 3;
    localparam int set_len     = 3;
    localparam int set_count   = 8;
    localparam int way_len     = 2;
    localparam int way_count   = 4;
    localparam int tag_len     = 10;
    localparam int block_bits  = 64;
    localparam int word_len    = 32;

    // memory tag zero means no transaction
    localparam int mem_tag_len = 4;

    localparam int buffer_len  = 2;
    localparam int buffer_size = 4;
    localparam int preg_len    = 6;
    localparam int rob_len     = 5;

    typedef enum logic [1:0] {
        mem_byte,
        mem_half,
        mem_word,
        mem_double
    } mem_size_t;

    typedef enum logic [1:0] {
        bus_none,
        bus_load,
        bus_store
    } bus_command_t;

    typedef struct packed {
        logic [tag_len-1:0]    tag;
        logic [set_len-1:0]    set;
        logic [offset_len-1:0] offset;
    } cache_addr_t;

    typedef struct packed {
        cache_addr_t          addr;
        mem_size_t            size;
        logic                 is_signed;
        logic [preg_len-1:0]  preg;
        logic [rob_len-1:0]   rob;
    } load_request_t;

    typedef struct packed {
        cache_addr_t          addr;
        mem_size_t            size;
        logic [word_len-1:0]  data;
    } store_request_t;

    typedef struct packed {
        logic                   valid;
        logic                   done;
        logic [mem_tag_len-1:0] mem_tag;
        load_request_t          request;
        logic [block_bits-1:0]  block;
    } miss_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [word_len-1:0]  value;
        logic [preg_len-1:0]  preg;
        logic [rob_len-1:0]   rob;
    } load_result_t;

    typedef struct packed {
        bus_command_t          command;
        logic [addr_len-1:0]   addr;
        mem_size_t             size;
        logic [block_bits-1:0] data;
    } mem_request_t;

    typedef struct packed {
        logic                   grant_valid;
        logic [mem_tag_len-1:0] grant_tag;
        logic [mem_tag_len-1:0] return_tag;
        logic [block_bits-1:0]  return_data;
    } mem_response_t;

endpackage
